// File: Bender.yml
package:
  name: enable_gen

sources:
  - logic/enable_gen_pkg.sv
  - logic/axil_if.sv
  - logic/axil_register_bank.sv
  - logic/period_counter.sv
  - logic/enable_generator.sv
  - logic/enable_gen_top.sv
  - target: simulation
    files:
      - dv/enable_gen_tb.sv

// File: dv/enable_gen_tb.sv
/*
 * Enable generator testbench
 * Applies a table of AXI-lite accesses, external run levels and pulse
 * windows to the top level, with random response stalls, and checks the
 * read data, the responses and the spacing and phase of the pulse trains.
 */
`timescale 1ns/1ps

module enable_gen_tb import enable_gen_pkg::*; ();

    localparam int clk_period = 100;
    localparam int wait_limit = 20;
    localparam int max_rises  = 16;
    localparam int max_steps  = 48;

    typedef enum logic [1:0] {
        op_write,
        op_read,
        op_ext,
        op_window
    } step_op_e;

    // In a window row data holds the length in cycles and exp_data the output mask
    typedef struct packed {
        step_op_e    op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
    } step_t;

    logic        clock;
    logic        rst_n;
    logic        gen_enable_in;
    logic [2:0]  enable_out;
    logic [7:0]  s_axil_awaddr;
    logic        s_axil_awvalid;
    logic        s_axil_awready;
    logic [31:0] s_axil_wdata;
    logic [3:0]  s_axil_wstrb;
    logic        s_axil_wvalid;
    logic        s_axil_wready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_bvalid;
    logic        s_axil_bready;
    logic [7:0]  s_axil_araddr;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        s_axil_rvalid;
    logic        s_axil_rready;

    step_t       steps [max_steps];
    int          n_steps;
    int          value_errors;
    int          timeout_errors;
    logic [15:0] shadow_period;
    logic [15:0] shadow_thr [3];
    time         rise_at [3][max_rises];
    int          rise_cnt [3];
    int          wide_cnt [3];
    logic [2:0]  last_out;
    logic [1:0]  got_resp;
    logic [31:0] got_data;

    enable_gen_top #(
        .N_ENABLES     (3),
        .COUNTER_WIDTH (16)
    ) enable_gen_top_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .gen_enable_in  (gen_enable_in),
        .enable_out     (enable_out),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready)
    );

    always #(clk_period / 2) clock = ~clock;

    // The pulse monitor samples mid-cycle where the outputs are settled
    always @(negedge clock) begin
        for (int i = 0; i < 3; i++) begin
            if (enable_out[i] === 1'b1 && last_out[i] !== 1'b1) begin
                if (rise_cnt[i] < max_rises) begin
                    rise_at[i][rise_cnt[i]] = $time;
                    rise_cnt[i] = rise_cnt[i] + 1;
                end
            end else if (enable_out[i] === 1'b1 && last_out[i] === 1'b1) begin
                // High on two samples in a row means a pulse wider than one cycle
                wide_cnt[i] = wide_cnt[i] + 1;
            end
        end
        last_out = enable_out;
    end

    task automatic report_mismatch(input string msg);
        value_errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("Timed out at %0t while waiting for %s", $time, what);
    endtask

    task automatic add_step(input step_op_e op, input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        steps[n_steps] = '{op, addr, data, strb, exp_data, exp_resp};
        n_steps++;
    endtask

    // Only the strobed bytes of the modelled register change and bits above 16 are dropped
    function automatic logic [15:0] apply_strobes(input logic [15:0] old_value,
                                                  input logic [31:0] data,
                                                  input logic [3:0] strb);
        logic [31:0] byte_mask;
        byte_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return 16'(({16'h0, old_value} & ~byte_mask) | (data & byte_mask));
    endfunction

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        int waited;
        int stall;
        @(posedge clock);
        s_axil_awaddr  <= addr;
        s_axil_wdata   <= data;
        s_axil_wstrb   <= strb;
        s_axil_awvalid <= 1'b1;
        s_axil_wvalid  <= 1'b1;
        waited = 0;
        @(negedge clock);
        while (s_axil_awready !== 1'b1 && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (s_axil_awready !== 1'b1) report_timeout("awready and wready");
        if (s_axil_wready !== s_axil_awready)
            report_mismatch("awready and wready did not rise together");
        @(posedge clock);
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        // A read offered during the pending response must be held off
        s_axil_araddr  <= reg_period_offset;
        s_axil_arvalid <= 1'b1;
        waited = 0;
        @(negedge clock);
        while (s_axil_bvalid !== 1'b1 && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (s_axil_bvalid !== 1'b1) report_timeout("bvalid");
        resp  = s_axil_bresp;
        stall = $urandom_range(0, 5);
        for (int c = 0; c <= stall; c++) begin
            if (c > 0) @(negedge clock);
            if (s_axil_bvalid !== 1'b1 || s_axil_bresp !== resp)
                report_mismatch("bvalid or bresp changed while bready was low");
            if (s_axil_arready !== 1'b0)
                report_mismatch("read accepted while a write response was pending");
        end
        @(posedge clock);
        s_axil_bready  <= 1'b1;
        s_axil_arvalid <= 1'b0;
        @(posedge clock);
        s_axil_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        int stall;
        @(posedge clock);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        waited = 0;
        @(negedge clock);
        while (s_axil_arready !== 1'b1 && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (s_axil_arready !== 1'b1) report_timeout("arready");
        @(posedge clock);
        s_axil_arvalid <= 1'b0;
        // This unmapped write probe must wait for the read response
        s_axil_awaddr  <= 8'h40;
        s_axil_wstrb   <= 4'hf;
        s_axil_awvalid <= 1'b1;
        s_axil_wvalid  <= 1'b1;
        waited = 0;
        @(negedge clock);
        while (s_axil_rvalid !== 1'b1 && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (s_axil_rvalid !== 1'b1) report_timeout("rvalid");
        data  = s_axil_rdata;
        resp  = s_axil_rresp;
        stall = $urandom_range(0, 5);
        for (int c = 0; c <= stall; c++) begin
            if (c > 0) @(negedge clock);
            if (s_axil_rvalid !== 1'b1 || s_axil_rdata !== data || s_axil_rresp !== resp)
                report_mismatch("rvalid, rdata or rresp changed while rready was low");
            if (s_axil_awready !== 1'b0 || s_axil_wready !== 1'b0)
                report_mismatch("write accepted while a read response was pending");
        end
        @(posedge clock);
        s_axil_rready  <= 1'b1;
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        @(posedge clock);
        s_axil_rready <= 1'b0;
    endtask

    // Watches the outputs for a number of cycles, then checks spacing, width and phase
    task automatic check_window(input int cycles, input logic [2:0] mask);
        time start_t;
        int  gap;
        int  lag;
        int  want_lag;
        int  k;
        @(posedge clock);
        for (int i = 0; i < 3; i++) begin
            rise_cnt[i] = 0;
            wide_cnt[i] = 0;
        end
        start_t = $time;
        repeat (cycles) @(posedge clock);
        for (int i = 0; i < 3; i++) begin
            if (mask[i]) begin
                if (rise_cnt[i] < 2)
                    report_mismatch($sformatf("enable_out[%0d] pulsed %0d times",
                                              i, rise_cnt[i]));
                for (int p = 1; p < rise_cnt[i]; p++) begin
                    gap = int'((rise_at[i][p] - rise_at[i][p-1]) / clk_period);
                    if (gap != int'(shadow_period))
                        report_mismatch($sformatf("enable_out[%0d] spacing %0d, expected %0d",
                                                  i, gap, shadow_period));
                end
            end else begin
                // Two cycles of grace for pulses already under way when the run stopped
                for (int p = 0; p < rise_cnt[i]; p++) begin
                    if ((rise_at[i][p] - start_t) / clk_period > 2)
                        report_mismatch($sformatf("unexpected pulse on enable_out[%0d]", i));
                end
            end
            if (wide_cnt[i] != 0)
                report_mismatch($sformatf("enable_out[%0d] high for more than one cycle", i));
        end
        if (mask[0] && rise_cnt[0] > 0 && shadow_period > 1) begin
            for (int i = 1; i < 3; i++) begin
                if (mask[i]) begin
                    k = 0;
                    while (k < rise_cnt[i] && rise_at[i][k] < rise_at[0][0]) k++;
                    want_lag = (int'(shadow_thr[i]) - int'(shadow_thr[0]) + int'(shadow_period))
                               % int'(shadow_period);
                    if (k >= rise_cnt[i]) begin
                        report_mismatch($sformatf("no pulse on enable_out[%0d] after output 0", i));
                    end else begin
                        lag = int'((rise_at[i][k] - rise_at[0][0]) / clk_period);
                        if (lag != want_lag)
                            report_mismatch($sformatf("enable_out[%0d] lags by %0d, expected %0d",
                                                      i, lag, want_lag));
                    end
                end
            end
        end
    endtask

    initial begin
        clock          = 1'b0;
        rst_n          = 1'b0;
        gen_enable_in  = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        last_out       = '0;
        value_errors   = 0;
        timeout_errors = 0;
        n_steps        = 0;
        shadow_period  = '0;
        for (int i = 0; i < 3; i++) begin
            shadow_thr[i] = '0;
            rise_cnt[i]   = 0;
            wide_cnt[i]   = 0;
        end
        void'($urandom(92));

        // After reset the outputs are quiet and every register reads zero
        add_step(op_window, 8'h00, 32'd8, 4'h0, 32'h0, okay);
        add_step(op_read, 8'h00, 32'h0, 4'h0, 32'h0, okay);
        add_step(op_read, 8'h04, 32'h0, 4'h0, 32'h0, okay);
        add_step(op_read, 8'h08, 32'h0, 4'h0, 32'h0, okay);
        add_step(op_read, 8'h0c, 32'h0, 4'h0, 32'h0, okay);
        add_step(op_read, 8'h10, 32'h0, 4'h0, 32'h0, okay);
        // Read back, width masking, byte strobes and the error responses
        add_step(op_write, 8'h00, 32'hffff_ffff, 4'hf, 32'h0, okay);
        add_step(op_read, 8'h00, 32'h0, 4'h0, 32'h0000_0001, okay);
        add_step(op_write, 8'h04, 32'habcd_1234, 4'hf, 32'h0, okay);
        add_step(op_read, 8'h04, 32'h0, 4'h0, 32'h0000_1234, okay);
        add_step(op_write, 8'h04, 32'h0000_5600, 4'h2, 32'h0, okay);
        add_step(op_read, 8'h04, 32'h0, 4'h0, 32'h0000_5634, okay);
        add_step(op_write, 8'h08, 32'h1234_5678, 4'hf, 32'h0, okay);
        add_step(op_read, 8'h08, 32'h0, 4'h0, 32'h0000_5678, okay);
        add_step(op_write, 8'h0c, 32'hffff_ffff, 4'hf, 32'h0, okay);
        add_step(op_read, 8'h0c, 32'h0, 4'h0, 32'h0000_ffff, okay);
        add_step(op_write, 8'h10, 32'h0001_0003, 4'h5, 32'h0, okay);
        add_step(op_read, 8'h10, 32'h0, 4'h0, 32'h0000_0003, okay);
        add_step(op_write, 8'h20, 32'hdead_beee, 4'hf, 32'h0, slverr);
        add_step(op_write, 8'h05, 32'hdead_beee, 4'hf, 32'h0, slverr);
        add_step(op_read, 8'h20, 32'h0, 4'h0, 32'h0, slverr);
        add_step(op_read, 8'h06, 32'h0, 4'h0, 32'h0, slverr);
        add_step(op_read, 8'h04, 32'h0, 4'h0, 32'h0000_5634, okay);
        add_step(op_read, 8'h00, 32'h0, 4'h0, 32'h0000_0001, okay);
        add_step(op_write, 8'h00, 32'h0, 4'hf, 32'h0, okay);
        add_step(op_read, 8'h00, 32'h0, 4'h0, 32'h0, okay);
        // Period 10 with thresholds 2, 5 and 7 under the run bit
        add_step(op_write, 8'h04, 32'd10, 4'hf, 32'h0, okay);
        add_step(op_write, 8'h08, 32'd2, 4'hf, 32'h0, okay);
        add_step(op_write, 8'h0c, 32'd5, 4'hf, 32'h0, okay);
        add_step(op_write, 8'h10, 32'd7, 4'hf, 32'h0, okay);
        add_step(op_write, 8'h00, 32'd1, 4'hf, 32'h0, okay);
        add_step(op_window, 8'h00, 32'd40, 4'h0, 32'h7, okay);
        // Threshold beyond the period stays silent, then the run bit is cleared
        add_step(op_write, 8'h10, 32'd12, 4'hf, 32'h0, okay);
        add_step(op_window, 8'h00, 32'd40, 4'h0, 32'h3, okay);
        add_step(op_write, 8'h00, 32'd0, 4'hf, 32'h0, okay);
        add_step(op_window, 8'h00, 32'd20, 4'h0, 32'h0, okay);
        // Same trains from the external level
        add_step(op_write, 8'h10, 32'd7, 4'hf, 32'h0, okay);
        add_step(op_ext, 8'h00, 32'd1, 4'h0, 32'h0, okay);
        add_step(op_window, 8'h00, 32'd40, 4'h0, 32'h7, okay);
        add_step(op_ext, 8'h00, 32'd0, 4'h0, 32'h0, okay);
        add_step(op_window, 8'h00, 32'd20, 4'h0, 32'h0, okay);

        repeat (4) @(posedge clock);
        rst_n <= 1'b1;

        for (int s = 0; s < n_steps; s++) begin
            case (steps[s].op)
                op_write: begin
                    axil_write(steps[s].addr, steps[s].data, steps[s].strb, got_resp);
                    if (got_resp !== steps[s].exp_resp)
                        report_mismatch($sformatf("write 0x%02h answered %0d, expected %0d",
                                                  steps[s].addr, got_resp, steps[s].exp_resp));
                    if (steps[s].exp_resp == okay) begin
                        if (steps[s].addr == reg_period_offset)
                            shadow_period = apply_strobes(shadow_period, steps[s].data,
                                                          steps[s].strb);
                        for (int i = 0; i < 3; i++) begin
                            if (steps[s].addr == reg_threshold_base + 8'(4 * i))
                                shadow_thr[i] = apply_strobes(shadow_thr[i], steps[s].data,
                                                              steps[s].strb);
                        end
                    end
                end
                op_read: begin
                    axil_read(steps[s].addr, got_data, got_resp);
                    if (got_data !== steps[s].exp_data || got_resp !== steps[s].exp_resp)
                        report_mismatch($sformatf(
                            "read 0x%02h gave 0x%08h/%0d, expected 0x%08h/%0d",
                            steps[s].addr, got_data, got_resp,
                            steps[s].exp_data, steps[s].exp_resp));
                end
                op_ext: begin
                    @(posedge clock);
                    gen_enable_in <= steps[s].data[0];
                end
                default: begin
                    check_window(int'(steps[s].data), steps[s].exp_data[2:0]);
                end
            endcase
        end

        $display("Errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: logic/axil_if.sv
/*
 * AXI-lite bus interface
 * Carries the five AXI-lite channels without the protection signals.
 * The master modport drives requests, the slave modport the responses.
 */
`timescale 1ns/1ps

interface axil_if import enable_gen_pkg::*; ();

    // Write address channel
    logic [axil_addr_width-1:0] awaddr;
    logic                       awvalid;
    logic                       awready;

    // Write data channel
    logic [axil_data_width-1:0] wdata;
    logic [axil_strb_width-1:0] wstrb;
    logic                       wvalid;
    logic                       wready;

    // Write response channel
    axil_resp_e                 bresp;
    logic                       bvalid;
    logic                       bready;

    // Read address channel
    logic [axil_addr_width-1:0] araddr;
    logic                       arvalid;
    logic                       arready;

    // Read data channel
    logic [axil_data_width-1:0] rdata;
    axil_resp_e                 rresp;
    logic                       rvalid;
    logic                       rready;

    // The master issues requests and accepts the responses
    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    // The slave accepts requests and returns responses
    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

// File: logic/axil_register_bank.sv
/*
 * AXI-lite register bank
 * Holds the run bit, the period and one threshold per enable output.
 * Accepts one request at a time, writes have priority over reads,
 * and unmapped or unaligned addresses are answered with SLVERR.
 */
`timescale 1ns/1ps

module axil_register_bank import enable_gen_pkg::*; #(
    parameter int N_ENABLES     = 3,
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                     clock,
    input  logic                     rst_n,
    axil_if.slave                    axil,
    output logic                     run_bit,
    output logic [COUNTER_WIDTH-1:0] period,
    output logic [COUNTER_WIDTH-1:0] thresholds [N_ENABLES]
);

    bank_state_e                state;
    logic                       write_accept;
    logic                       read_accept;
    logic                       wr_hit_control;
    logic                       wr_hit_period;
    logic [N_ENABLES-1:0]       wr_hit_threshold;
    logic                       wr_addr_ok;
    logic [axil_data_width-1:0] control_merged;
    logic [axil_data_width-1:0] period_merged;
    logic [axil_data_width-1:0] threshold_merged [N_ENABLES];
    logic [axil_data_width-1:0] rd_word;
    logic                       rd_addr_ok;

    // Replaces the bytes of old_word whose strobe bit is set
    function automatic logic [axil_data_width-1:0] strobe_merge(
        input logic [axil_data_width-1:0] old_word,
        input logic [axil_data_width-1:0] new_word,
        input logic [axil_strb_width-1:0] strb
    );
        logic [axil_data_width-1:0] result;
        result = old_word;
        for (int b = 0; b < axil_strb_width; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Both write channels must be valid together, a read only wins when no write is offered
    assign write_accept = (state == idle) && axil.awvalid && axil.wvalid;
    assign read_accept  = (state == idle) && axil.arvalid && !write_accept;

    assign axil.awready = write_accept;
    assign axil.wready  = write_accept;
    assign axil.arready = read_accept;
    assign axil.bvalid  = (state == write_resp);
    assign axil.rvalid  = (state == read_resp);

    // Only exact word addresses match, so unaligned accesses fall out of the map
    always_comb begin
        wr_hit_control = (axil.awaddr == reg_control_offset);
        wr_hit_period  = (axil.awaddr == reg_period_offset);
        for (int i = 0; i < N_ENABLES; i++) begin
            wr_hit_threshold[i] = (axil.awaddr == reg_threshold_base + 4 * i);
        end
    end

    assign wr_addr_ok = wr_hit_control || wr_hit_period || (|wr_hit_threshold);

    // Current contents widened to a bus word, then merged with the strobed bytes
    always_comb begin
        control_merged = strobe_merge(axil_data_width'(run_bit), axil.wdata, axil.wstrb);
        period_merged  = strobe_merge(axil_data_width'(period), axil.wdata, axil.wstrb);
        for (int i = 0; i < N_ENABLES; i++) begin
            threshold_merged[i] = strobe_merge(axil_data_width'(thresholds[i]),
                                               axil.wdata, axil.wstrb);
        end
    end

    // Read mux, bits above the stored width come back as zero
    always_comb begin
        rd_word    = '0;
        rd_addr_ok = 1'b0;
        if (axil.araddr == reg_control_offset) begin
            rd_word    = axil_data_width'(run_bit);
            rd_addr_ok = 1'b1;
        end else if (axil.araddr == reg_period_offset) begin
            rd_word    = axil_data_width'(period);
            rd_addr_ok = 1'b1;
        end
        for (int i = 0; i < N_ENABLES; i++) begin
            if (axil.araddr == reg_threshold_base + 4 * i) begin
                rd_word    = axil_data_width'(thresholds[i]);
                rd_addr_ok = 1'b1;
            end
        end
    end

    // FSM and register storage
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= idle;
            run_bit <= 1'b0;
            period  <= '0;
            for (int i = 0; i < N_ENABLES; i++) begin
                thresholds[i] <= '0;
            end
        end else begin
            case (state)
                idle: begin
                    if (write_accept) begin
                        // Registers change at the handshake edge itself
                        if (wr_hit_control) begin
                            run_bit <= control_merged[0];
                        end
                        if (wr_hit_period) begin
                            period <= period_merged[COUNTER_WIDTH-1:0];
                        end
                        for (int i = 0; i < N_ENABLES; i++) begin
                            if (wr_hit_threshold[i]) begin
                                thresholds[i] <= threshold_merged[i][COUNTER_WIDTH-1:0];
                            end
                        end
                        state <= write_resp;
                    end else if (read_accept) begin
                        state <= read_resp;
                    end
                end
                write_resp: begin
                    if (axil.bready) begin
                        state <= idle;
                    end
                end
                read_resp: begin
                    if (axil.rready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Response payloads are captured once per request and held until taken
    always_ff @(posedge clock) begin
        if (write_accept) begin
            if (wr_addr_ok) begin
                axil.bresp <= okay;
            end else begin
                axil.bresp <= slverr;
            end
        end
        if (read_accept) begin
            axil.rdata <= rd_word;
            if (rd_addr_ok) begin
                axil.rresp <= okay;
            end else begin
                axil.rresp <= slverr;
            end
        end
    end

    // A stalled write response keeps its valid and its code
    bresp_stable: assert property (@(posedge clock) disable iff (!rst_n)
        axil.bvalid && !axil.bready |=> axil.bvalid && $stable(axil.bresp));

    // A stalled read response keeps its valid, data and code
    rresp_stable: assert property (@(posedge clock) disable iff (!rst_n)
        axil.rvalid && !axil.rready |=>
            axil.rvalid && $stable(axil.rdata) && $stable(axil.rresp));

endmodule

// File: logic/enable_gen_pkg.sv
/*
 * Enable generator shared definitions
 * Holds the AXI-lite bus widths, the register map offsets of the
 * enable generator and the enums for bus responses and bank states.
 */
package enable_gen_pkg;

    // AXI-lite byte address width, enough for the control, period and thresholds
    localparam int unsigned axil_addr_width = 8;

    // AXI-lite data width, one register per 32-bit word
    localparam int unsigned axil_data_width = 32;

    // One strobe bit per data byte
    localparam int unsigned axil_strb_width = axil_data_width / 8;

    // Control register, only bit 0 is stored and acts as the run bit
    localparam logic [axil_addr_width-1:0] reg_control_offset = 8'h00;

    // Period of the pulse trains in clock cycles
    localparam logic [axil_addr_width-1:0] reg_period_offset = 8'h04;

    // Threshold i sits at this address plus 4 times i
    localparam logic [axil_addr_width-1:0] reg_threshold_base = 8'h08;

    // AXI response codes, EXOKAY and DECERR are never produced here
    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10
    } axil_resp_e;

    // Register bank FSM states
    // A response state is held until the master takes the response
    typedef enum logic [1:0] {
        idle,
        write_resp,
        read_resp
    } bank_state_e;

endpackage

// File: logic/enable_gen_top.sv
/*
 * Enable generator top level
 * Collects the flat AXI-lite ports into one bus and hands it to the generator.
 */
`timescale 1ns/1ps

module enable_gen_top import enable_gen_pkg::*; #(
    parameter int N_ENABLES     = 3,
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       gen_enable_in,
    output logic [N_ENABLES-1:0]       enable_out,

    // AXI-lite slave port
    input  logic [axil_addr_width-1:0] s_axil_awaddr,
    input  logic                       s_axil_awvalid,
    output logic                       s_axil_awready,
    input  logic [axil_data_width-1:0] s_axil_wdata,
    input  logic [axil_strb_width-1:0] s_axil_wstrb,
    input  logic                       s_axil_wvalid,
    output logic                       s_axil_wready,
    output logic [1:0]                 s_axil_bresp,
    output logic                       s_axil_bvalid,
    input  logic                       s_axil_bready,
    input  logic [axil_addr_width-1:0] s_axil_araddr,
    input  logic                       s_axil_arvalid,
    output logic                       s_axil_arready,
    output logic [axil_data_width-1:0] s_axil_rdata,
    output logic [1:0]                 s_axil_rresp,
    output logic                       s_axil_rvalid,
    input  logic                       s_axil_rready
);

    axil_if axil ();

    // Requests from the ports onto the bus
    assign axil.awaddr  = s_axil_awaddr;
    assign axil.awvalid = s_axil_awvalid;
    assign axil.wdata   = s_axil_wdata;
    assign axil.wstrb   = s_axil_wstrb;
    assign axil.wvalid  = s_axil_wvalid;
    assign axil.bready  = s_axil_bready;
    assign axil.araddr  = s_axil_araddr;
    assign axil.arvalid = s_axil_arvalid;
    assign axil.rready  = s_axil_rready;

    // Responses back out, enum codes leave as raw two-bit values
    assign s_axil_awready = axil.awready;
    assign s_axil_wready  = axil.wready;
    assign s_axil_bresp   = axil.bresp;
    assign s_axil_bvalid  = axil.bvalid;
    assign s_axil_arready = axil.arready;
    assign s_axil_rdata   = axil.rdata;
    assign s_axil_rresp   = axil.rresp;
    assign s_axil_rvalid  = axil.rvalid;

    enable_generator #(
        .N_ENABLES     (N_ENABLES),
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) enable_generator_inst (
        .clock         (clock),
        .rst_n         (rst_n),
        .gen_enable_in (gen_enable_in),
        .enable_out    (enable_out),
        .axil          (axil)
    );

endmodule

// File: logic/enable_generator.sv
/*
 * Enable pulse generator
 * A register bank programs a common period and one threshold per output.
 * Each output pulses for one cycle after the shared count meets its
 * threshold, which gives pulse trains of equal period and fixed phase.
 */
`timescale 1ns/1ps

module enable_generator #(
    parameter int N_ENABLES     = 3,
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 gen_enable_in,
    output logic [N_ENABLES-1:0] enable_out,
    axil_if.slave                axil
);

    logic                     run_bit;
    logic [COUNTER_WIDTH-1:0] period;
    logic [COUNTER_WIDTH-1:0] thresholds [N_ENABLES];
    logic [COUNTER_WIDTH-1:0] count;
    logic                     run_level;

    // The bus side holds the run bit, the period and the thresholds
    axil_register_bank #(
        .N_ENABLES     (N_ENABLES),
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) axil_register_bank_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .axil       (axil),
        .run_bit    (run_bit),
        .period     (period),
        .thresholds (thresholds)
    );

    // Either software or the external level may run the generator
    assign run_level = run_bit | gen_enable_in;

    // Shared timebase for all outputs
    period_counter #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) period_counter_inst (
        .clock  (clock),
        .rst_n  (rst_n),
        .run    (run_level),
        .period (period),
        .count  (count)
    );

    // One comparator per output
    // Each is a single compare followed by one flop, so every output lags its
    // threshold match by exactly one cycle and the relative phases are kept
    for (genvar i = 0; i < N_ENABLES; i++) begin : g_comparator
        logic hit;

        // Matches count only while running and only for a threshold below the period
        assign hit = run_level && (thresholds[i] < period) && (count == thresholds[i]);

        always_ff @(posedge clock) begin
            if (!rst_n) begin
                enable_out[i] <= 1'b0;
            end else begin
                enable_out[i] <= hit;
            end
        end
    end

endmodule

// File: logic/period_counter.sv
/*
 * Period counter
 * Free-running count from zero to period minus one while run is high,
 * held at zero while run is low.
 */
`timescale 1ns/1ps

module period_counter #(
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic [COUNTER_WIDTH-1:0] period,
    output logic [COUNTER_WIDTH-1:0] count
);

    logic [COUNTER_WIDTH-1:0] last_count;
    logic                     wrap;

    // Last value of the count before it returns to zero
    assign last_count = period - COUNTER_WIDTH'(1);

    // A period of 0 or 1 pins the count at zero
    // Comparing with >= also recovers when the period shrinks below the count
    assign wrap = (period <= COUNTER_WIDTH'(1)) || (count >= last_count);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run) begin
            // Stopping restarts the phase, the next run begins from zero
            count <= '0;
        end else if (wrap) begin
            count <= '0;
        end else begin
            count <= count + COUNTER_WIDTH'(1);
        end
    end

    // Once running with a steady period, the count never reaches the period
    count_in_range: assert property (@(posedge clock) disable iff (!rst_n)
        run && $past(run) && (period > COUNTER_WIDTH'(1)) && (period == $past(period))
            |-> count < period);

endmodule

// File: vlog.f
logic/enable_gen_pkg.sv
logic/axil_if.sv
logic/axil_register_bank.sv
logic/period_counter.sv
logic/enable_generator.sv
logic/enable_gen_top.sv
dv/enable_gen_tb.sv
